/* source/rv_pkg.sv */
package rv_pkg;

    // defaults the top level hands to its parameters
    localparam int XLEN_DEFAULT     = 32;
    localparam int REG_ADDR_DEFAULT = 5;   // 32 registers, 4 gives RV32E-style

    typedef logic [31:0] instr_t;    // raw instruction word
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;
    typedef logic [4:0]  reg_idx_t;  // register field as encoded, always 5 bits
    typedef logic [3:0]  alu_op_t;

    // major opcodes of the subset
    localparam opcode_t OP_REG = 7'b0110011;  // R-type alu
    localparam opcode_t OP_IMM = 7'b0010011;  // I-type alu
    localparam opcode_t OP_LUI = 7'b0110111;

    // funct3, shared by R and I forms
    localparam funct3_t F3_ADD  = 3'b000;  // add / sub / addi
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SRL  = 3'b101;  // srl / sra, split by funct7
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000;  // sub, sra, srai

    // alu operation codes
    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_AND    = 4'd2;
    localparam alu_op_t ALU_OR     = 4'd3;
    localparam alu_op_t ALU_XOR    = 4'd4;
    localparam alu_op_t ALU_SLL    = 4'd5;
    localparam alu_op_t ALU_SRL    = 4'd6;
    localparam alu_op_t ALU_SRA    = 4'd7;
    localparam alu_op_t ALU_SLT    = 4'd8;
    localparam alu_op_t ALU_SLTU   = 4'd9;
    localparam alu_op_t ALU_PASS_B = 4'd10;  // lui, operand b straight through

endpackage

/* source/regfile.sv */
module regfile import rv_pkg::*; #(
    parameter int DATA_WIDTH     = XLEN_DEFAULT,
    parameter int REG_ADDR_WIDTH = REG_ADDR_DEFAULT
) (
    input  logic                      clk,
    input  logic [REG_ADDR_WIDTH-1:0] rs1,        // read index 1
    input  logic [REG_ADDR_WIDTH-1:0] rs2,        // read index 2
    input  logic [REG_ADDR_WIDTH-1:0] rd,         // write index, from W
    input  logic                      reg_write,  // write enable, from W
    input  logic [DATA_WIDTH-1:0]     result_w,   // write data
    output logic [DATA_WIDTH-1:0]     rd1,
    output logic [DATA_WIDTH-1:0]     rd2,
    output logic [DATA_WIDTH-1:0]     a0          // live x10
);

    localparam int NUM_REGS = 2**REG_ADDR_WIDTH;
    localparam int A0_IDX   = 10;

    // no reset on the array, contents start undefined
    logic [DATA_WIDTH-1:0] regs [NUM_REGS];

    assign a0 = regs[A0_IDX];  // permanent tap

    // x0 reads zero whatever the array holds
    always_comb begin
        rd1 = (rs1 == '0) ? '0 : regs[rs1];
        rd2 = (rs2 == '0) ? '0 : regs[rs2];
    end

    // write on the falling edge, so a D-stage read later in the
    // same cycle already sees the W result
    always_ff @(negedge clk) begin
        if (reg_write && rd != '0) begin
            regs[rd] <= result_w;
        end
    end

endmodule

/* source/decoder.sv */
module decoder import rv_pkg::*; #(
    parameter int DATA_WIDTH     = XLEN_DEFAULT,
    parameter int REG_ADDR_WIDTH = REG_ADDR_DEFAULT
) (
    input  instr_t                    instr,
    output logic [REG_ADDR_WIDTH-1:0] rs1,
    output logic [REG_ADDR_WIDTH-1:0] rs2,
    output logic [REG_ADDR_WIDTH-1:0] rd,
    output logic [DATA_WIDTH-1:0]     imm,        // sign-extended I or U immediate
    output logic                      use_imm,    // operand b from imm
    output alu_op_t                   alu_op,
    output logic                      reg_write,
    output logic                      illegal
);

    localparam int NUM_REGS = 2**REG_ADDR_WIDTH;

    opcode_t               opcode;
    funct3_t               funct3;
    funct7_t               funct7;
    reg_idx_t              rs1_f;
    reg_idx_t              rs2_f;
    reg_idx_t              rd_f;
    logic [DATA_WIDTH-1:0] imm_i;
    logic [DATA_WIDTH-1:0] imm_u;
    logic                  legal_op;   // opcode/funct combination known
    logic                  uses_rs1;
    logic                  uses_rs2;
    logic                  idx_bad;    // some used index beyond the file
    logic                  is_shift;

    // R and I share the funct3 map; alt picks sub / sra
    function automatic alu_op_t f3_to_op(funct3_t f3, logic alt);
        alu_op_t op;
        case (f3)
            F3_ADD:  op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  op = ALU_SLL;
            F3_SLT:  op = ALU_SLT;
            F3_SLTU: op = ALU_SLTU;
            F3_XOR:  op = ALU_XOR;
            F3_SRL:  op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:   op = ALU_OR;
            F3_AND:  op = ALU_AND;
            default: op = ALU_ADD;
        endcase
        return op;
    endfunction

    assign opcode = instr[6:0];
    assign rd_f   = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1_f  = instr[19:15];
    assign rs2_f  = instr[24:20];
    assign funct7 = instr[31:25];

    // low bits only, the range check below catches the rest
    assign rs1 = rs1_f[REG_ADDR_WIDTH-1:0];
    assign rs2 = rs2_f[REG_ADDR_WIDTH-1:0];
    assign rd  = rd_f[REG_ADDR_WIDTH-1:0];

    assign imm_i    = DATA_WIDTH'($signed(instr[31:20]));           // 12-bit, sign-extended
    assign imm_u    = DATA_WIDTH'($signed({instr[31:12], 12'b0}));  // lui upper immediate
    assign is_shift = (funct3 == F3_SLL) || (funct3 == F3_SRL);

    always_comb begin
        legal_op = 1'b0;
        use_imm  = 1'b0;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        imm      = imm_i;
        alu_op   = ALU_ADD;
        case (opcode)
            OP_REG: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                // alt funct7 only exists for sub and sra
                legal_op = (funct7 == F7_BASE) ||
                           (funct7 == F7_ALT && (funct3 == F3_ADD || funct3 == F3_SRL));
                alu_op   = f3_to_op(funct3, funct7 == F7_ALT);
            end
            OP_IMM: begin
                uses_rs1 = 1'b1;
                use_imm  = 1'b1;
                // funct7 is immediate bits except on shifts
                legal_op = !is_shift || (funct7 == F7_BASE) ||
                           (funct3 == F3_SRL && funct7 == F7_ALT);
                alu_op   = f3_to_op(funct3, is_shift && funct7 == F7_ALT);
            end
            OP_LUI: begin
                legal_op = 1'b1;
                use_imm  = 1'b1;
                imm      = imm_u;
                alu_op   = ALU_PASS_B;
            end
            default: legal_op = 1'b0;  // anything else is illegal
        endcase
    end

    // constant false when REG_ADDR_WIDTH is 5
    assign idx_bad = (int'(rd_f) >= NUM_REGS) ||
                     (uses_rs1 && int'(rs1_f) >= NUM_REGS) ||
                     (uses_rs2 && int'(rs2_f) >= NUM_REGS);

    assign illegal   = !legal_op || idx_bad;
    assign reg_write = !illegal && (rd_f != '0);  // x0 destination never writes

endmodule

/* source/alu.sv */
module alu import rv_pkg::*; #(
    parameter int DATA_WIDTH = XLEN_DEFAULT
) (
    input  logic [DATA_WIDTH-1:0] op_a,
    input  logic [DATA_WIDTH-1:0] op_b,    // forwarded rs2 or immediate
    input  alu_op_t               alu_op,
    output logic [DATA_WIDTH-1:0] result
);

    localparam int SHAMT_WIDTH = $clog2(DATA_WIDTH);

    logic [SHAMT_WIDTH-1:0] shamt;        // low bits of b only
    logic                   lt_signed;
    logic                   lt_unsigned;

    assign shamt       = op_b[SHAMT_WIDTH-1:0];
    assign lt_signed   = $signed(op_a) < $signed(op_b);
    assign lt_unsigned = op_a < op_b;

    always_comb begin
        case (alu_op)
            ALU_ADD:    result = op_a + op_b;
            ALU_SUB:    result = op_a - op_b;
            ALU_AND:    result = op_a & op_b;
            ALU_OR:     result = op_a | op_b;
            ALU_XOR:    result = op_a ^ op_b;
            ALU_SLL:    result = op_a << shamt;
            ALU_SRL:    result = op_a >> shamt;
            // arithmetic, sign bit fills from the left
            ALU_SRA:    result = $signed(op_a) >>> shamt;
            // compares give 0 or 1, zero-extended
            ALU_SLT:    result = DATA_WIDTH'(lt_signed);
            ALU_SLTU:   result = DATA_WIDTH'(lt_unsigned);
            ALU_PASS_B: result = op_b;  // lui
            default:    result = '0;
        endcase
    end

endmodule

/* source/forward_unit.sv */
module forward_unit import rv_pkg::*; #(
    parameter int DATA_WIDTH     = XLEN_DEFAULT,
    parameter int REG_ADDR_WIDTH = REG_ADDR_DEFAULT
) (
    input  logic [REG_ADDR_WIDTH-1:0] rs1_e,        // E-stage source indices
    input  logic [REG_ADDR_WIDTH-1:0] rs2_e,
    input  logic [DATA_WIDTH-1:0]     rd1_e,        // read data registered in D
    input  logic [DATA_WIDTH-1:0]     rd2_e,
    input  logic [REG_ADDR_WIDTH-1:0] rd_w,
    input  logic                      reg_write_w,
    input  logic [DATA_WIDTH-1:0]     result_w,
    output logic [DATA_WIDTH-1:0]     fwd_a,
    output logic [DATA_WIDTH-1:0]     fwd_b
);

    logic w_live;  // W will write a real register this cycle
    logic hit_a;
    logic hit_b;

    assign w_live = reg_write_w && (rd_w != '0);
    assign hit_a  = w_live && (rd_w == rs1_e);
    assign hit_b  = w_live && (rd_w == rs2_e);

    // W result is newer than what D read a cycle ago
    assign fwd_a = hit_a ? result_w : rd1_e;
    assign fwd_b = hit_b ? result_w : rd2_e;

endmodule

/* source/exec_pipe.sv */
module exec_pipe import rv_pkg::*; #(
    parameter int DATA_WIDTH     = XLEN_DEFAULT,
    parameter int REG_ADDR_WIDTH = REG_ADDR_DEFAULT
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  instr_t                instr,
    input  logic                  instr_valid,    // plain strobe, no handshake
    output logic [DATA_WIDTH-1:0] a0,
    output logic                  illegal_instr   // one-cycle pulse, with E entry
);

    // D stage, combinational off instr
    logic [REG_ADDR_WIDTH-1:0] rs1_d;
    logic [REG_ADDR_WIDTH-1:0] rs2_d;
    logic [REG_ADDR_WIDTH-1:0] rd_d;
    logic [DATA_WIDTH-1:0]     imm_d;
    logic                      use_imm_d;
    alu_op_t                   alu_op_d;
    logic                      reg_write_d;
    logic                      illegal_d;
    logic [DATA_WIDTH-1:0]     rd1_d;       // regfile read data
    logic [DATA_WIDTH-1:0]     rd2_d;

    // E stage
    logic                      valid_e;
    logic                      reg_write_e;
    logic [REG_ADDR_WIDTH-1:0] rs1_e;
    logic [REG_ADDR_WIDTH-1:0] rs2_e;
    logic [REG_ADDR_WIDTH-1:0] rd_e;
    logic [DATA_WIDTH-1:0]     rd1_e;
    logic [DATA_WIDTH-1:0]     rd2_e;
    logic [DATA_WIDTH-1:0]     imm_e;
    logic                      use_imm_e;
    alu_op_t                   alu_op_e;
    logic [DATA_WIDTH-1:0]     fwd_a;
    logic [DATA_WIDTH-1:0]     fwd_b;
    logic [DATA_WIDTH-1:0]     op_b_e;      // after immediate select
    logic [DATA_WIDTH-1:0]     result_e;

    // W stage
    logic                      valid_w;
    logic                      reg_write_w;
    logic                      wen_w;       // qualified write enable
    logic [REG_ADDR_WIDTH-1:0] rd_w;
    logic [DATA_WIDTH-1:0]     result_w;

    decoder #(
        .DATA_WIDTH     (DATA_WIDTH),
        .REG_ADDR_WIDTH (REG_ADDR_WIDTH)
    ) decoder_inst (
        .instr     (instr),
        .rs1       (rs1_d),
        .rs2       (rs2_d),
        .rd        (rd_d),
        .imm       (imm_d),
        .use_imm   (use_imm_d),
        .alu_op    (alu_op_d),
        .reg_write (reg_write_d),
        .illegal   (illegal_d)
    );

    // read in D, written back from W on the falling edge
    regfile #(
        .DATA_WIDTH     (DATA_WIDTH),
        .REG_ADDR_WIDTH (REG_ADDR_WIDTH)
    ) regfile_inst (
        .clk       (clk),
        .rs1       (rs1_d),
        .rs2       (rs2_d),
        .rd        (rd_w),
        .reg_write (wen_w),
        .result_w  (result_w),
        .rd1       (rd1_d),
        .rd2       (rd2_d),
        .a0        (a0)
    );

    // D/E control, the only state that needs reset here
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_e       <= 1'b0;
            reg_write_e   <= 1'b0;
            illegal_instr <= 1'b0;
        end else begin
            valid_e       <= instr_valid;
            reg_write_e   <= instr_valid & reg_write_d;  // decoder already cleared on illegal
            illegal_instr <= instr_valid & illegal_d;    // high for the E cycle only
        end
    end

    // D/E payload, held across gaps
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            rs1_e     <= rs1_d;
            rs2_e     <= rs2_d;
            rd_e      <= rd_d;
            rd1_e     <= rd1_d;
            rd2_e     <= rd2_d;
            imm_e     <= imm_d;
            use_imm_e <= use_imm_d;
            alu_op_e  <= alu_op_d;
        end
    end

    // E-to-E dependency, W result substituted
    forward_unit #(
        .DATA_WIDTH     (DATA_WIDTH),
        .REG_ADDR_WIDTH (REG_ADDR_WIDTH)
    ) forward_unit_inst (
        .rs1_e       (rs1_e),
        .rs2_e       (rs2_e),
        .rd1_e       (rd1_e),
        .rd2_e       (rd2_e),
        .rd_w        (rd_w),
        .reg_write_w (wen_w),
        .result_w    (result_w),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b)
    );

    assign op_b_e = use_imm_e ? imm_e : fwd_b;  // imm wins over rs2

    alu #(
        .DATA_WIDTH (DATA_WIDTH)
    ) alu_inst (
        .op_a   (fwd_a),
        .op_b   (op_b_e),
        .alu_op (alu_op_e),
        .result (result_e)
    );

    // E/W control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_w     <= 1'b0;
            reg_write_w <= 1'b0;
        end else begin
            valid_w     <= valid_e;
            reg_write_w <= reg_write_e;
        end
    end

    // E/W payload
    always_ff @(posedge clk) begin
        if (valid_e) begin
            rd_w     <= rd_e;
            result_w <= result_e;
        end
    end

    // bubbles never write
    assign wen_w = valid_w & reg_write_w;

endmodule

/* bench/exec_pipe_asserts.sv */
module exec_pipe_asserts #(
    parameter int REG_ADDR_WIDTH = 5
) (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      instr_valid,
    input logic                      illegal_d,     // decoder flag in D
    input logic                      illegal_instr,
    input logic                      valid_w,
    input logic                      reg_write_w,
    input logic [REG_ADDR_WIDTH-1:0] rd_w
);

    timeunit 1ns;
    timeprecision 1ps;

    int   fail_count = 0;  // read by the testbench at the end
    logic illegal_seen;

    assign illegal_seen = instr_valid && illegal_d;

    // two-cycle pulse only from two illegal words in a row
    illegal_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        illegal_instr && $past(illegal_instr) |-> $past(illegal_seen, 1) && $past(illegal_seen, 2))
    else begin
        fail_count++;
        $error("illegal_instr held without back to back illegal words");
    end

    // bubbles carry no write
    write_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
        reg_write_w |-> valid_w)
    else begin
        fail_count++;
        $error("W write enable set with W valid clear");
    end

    write_not_x0: assert property (@(posedge clk) disable iff (!rst_n)
        reg_write_w |-> rd_w != '0)
    else begin
        fail_count++;
        $error("W write enable set for x0");
    end

endmodule

/* bench/exec_pipe_tb.sv */
module exec_pipe_tb import rv_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int A0 = 10;
    localparam int T0 = 5;
    localparam int T1 = 6;
    localparam int X0 = 0;
    localparam int MAX_CYCLES = 400;  // tests take about 230 cycles

    logic        clk;
    logic        rst_n;
    instr_t      instr;
    logic        instr_valid;
    logic [31:0] a0;
    logic        illegal_instr;

    logic [31:0] shadow [32];  // reference register file
    int          errors;
    int          cycles;

    exec_pipe exec_pipe_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr         (instr),
        .instr_valid   (instr_valid),
        .a0            (a0),
        .illegal_instr (illegal_instr)
    );

    bind exec_pipe exec_pipe_asserts #(
        .REG_ADDR_WIDTH (REG_ADDR_WIDTH)
    ) exec_pipe_asserts_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid   (instr_valid),
        .illegal_d     (illegal_d),
        .illegal_instr (illegal_instr),
        .valid_w       (valid_w),
        .reg_write_w   (reg_write_w),
        .rd_w          (rd_w)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period
    end

    function automatic instr_t enc_r(funct7_t f7, funct3_t f3, int rd, int rs1, int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OP_REG};
    endfunction

    function automatic instr_t enc_i(funct3_t f3, int rd, int rs1, logic [11:0] imm);
        return {imm, 5'(rs1), f3, 5'(rd), OP_IMM};
    endfunction

    function automatic instr_t enc_lui(int rd, logic [19:0] upper);
        return {upper, 5'(rd), OP_LUI};
    endfunction

    // picks one of the 19 ops writing t0 op t1 or t0 op imm into a0
    function automatic instr_t op_instr(int idx, logic [11:0] imm);
        case (idx)
            0:  return enc_r(F7_BASE, F3_ADD, A0, T0, T1);
            1:  return enc_r(F7_ALT, F3_ADD, A0, T0, T1);   // sub
            2:  return enc_r(F7_BASE, F3_AND, A0, T0, T1);
            3:  return enc_r(F7_BASE, F3_OR, A0, T0, T1);
            4:  return enc_r(F7_BASE, F3_XOR, A0, T0, T1);
            5:  return enc_r(F7_BASE, F3_SLL, A0, T0, T1);
            6:  return enc_r(F7_BASE, F3_SRL, A0, T0, T1);
            7:  return enc_r(F7_ALT, F3_SRL, A0, T0, T1);   // sra
            8:  return enc_r(F7_BASE, F3_SLT, A0, T0, T1);
            9:  return enc_r(F7_BASE, F3_SLTU, A0, T0, T1);
            10: return enc_i(F3_ADD, A0, T0, imm);
            11: return enc_i(F3_AND, A0, T0, imm);
            12: return enc_i(F3_OR, A0, T0, imm);
            13: return enc_i(F3_XOR, A0, T0, imm);
            14: return enc_i(F3_SLT, A0, T0, imm);
            15: return enc_i(F3_SLTU, A0, T0, imm);
            16: return enc_i(F3_SLL, A0, T0, {F7_BASE, imm[4:0]});
            17: return enc_i(F3_SRL, A0, T0, {F7_BASE, imm[4:0]});
            default: return enc_i(F3_SRL, A0, T0, {F7_ALT, imm[4:0]});  // srai
        endcase
    endfunction

    // ISA semantics of the subset applied to the shadow file
    task automatic model_step(input instr_t w);
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic        alt;
        logic        ok;
        rd  = w[11:7];
        alt = (w[31:25] == F7_ALT);
        a   = shadow[w[19:15]];
        b   = (w[6:0] == OP_REG) ? shadow[w[24:20]] : {{20{w[31]}}, w[31:20]};
        case (w[6:0])
            OP_REG:  ok = (w[31:25] == F7_BASE) ||
                          (alt && (w[14:12] == F3_ADD || w[14:12] == F3_SRL));
            OP_IMM:  ok = !(w[14:12] == F3_SLL || w[14:12] == F3_SRL) || (w[31:25] == F7_BASE)
                          || (alt && w[14:12] == F3_SRL);
            OP_LUI:  ok = 1'b1;
            default: ok = 1'b0;
        endcase
        case (w[14:12])
            F3_ADD:  res = (w[6:0] == OP_REG && alt) ? a - b : a + b;
            F3_SLL:  res = a << b[4:0];
            F3_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F3_SLTU: res = (a < b) ? 32'd1 : 32'd0;
            F3_XOR:  res = a ^ b;
            F3_SRL: begin
                if (alt)
                    res = $signed(a) >>> b[4:0];  // sign bit fills from the left
                else
                    res = a >> b[4:0];
            end
            F3_OR:   res = a | b;
            default: res = a & b;
        endcase
        if (w[6:0] == OP_LUI)
            res = {w[31:12], 12'b0};
        if (ok && rd != 5'd0)
            shadow[rd] = res;  // x0 stays zero
    endtask

    task automatic issue(input instr_t w);
        @(posedge clk);
        instr       <= w;
        instr_valid <= 1'b1;
        model_step(w);
    endtask

    // word on the bus with valid low is a bubble
    task automatic gap(input instr_t w);
        @(posedge clk);
        instr       <= w;
        instr_valid <= 1'b0;
    endtask

    task automatic check_a0(input logic [31:0] expected);
        assert (a0 === expected)
        else begin
            errors++;
            $display("FAIL %0t a0 expected %h got %h", $time, expected, a0);
        end
    endtask

    // a0 written on the falling edge after j+2 when the last issue was at edge j
    task automatic settle_and_check();
        @(posedge clk);
        instr_valid <= 1'b0;
        repeat (2) @(posedge clk);
        check_a0(shadow[A0]);
    endtask

    // lui plus addi with the upper part rounded for a negative low part
    task automatic load_reg(input int rd, input logic [31:0] value);
        logic [31:0] upper;
        upper = (value + 32'h800) >> 12;
        issue(enc_lui(rd, upper[19:0]));
        issue(enc_i(F3_ADD, rd, rd, value[11:0]));
    endtask

    task automatic expect_illegal(input instr_t w);
        issue(w);
        @(posedge clk);
        instr_valid <= 1'b0;
        @(negedge clk);  // inside the E cycle
        assert (illegal_instr === 1'b1)
        else begin
            errors++;
            $display("FAIL %0t illegal_instr expected 1 got %b", $time, illegal_instr);
        end
        @(negedge clk);
        assert (illegal_instr === 1'b0)
        else begin
            errors++;
            $display("FAIL %0t illegal_instr expected 0 got %b", $time, illegal_instr);
        end
        @(posedge clk);
        check_a0(shadow[A0]);  // unchanged
    endtask

    task automatic lui_addi_constant();
        load_reg(A0, 32'hDEAD_BEEF);  // low part 0xeef is negative
        settle_and_check();
        check_a0(32'hDEAD_BEEF);
        load_reg(A0, 32'h1234_5678);
        settle_and_check();
    endtask

    task automatic all_ops_random();
        logic [11:0] imm;
        for (int i = 0; i < 20; i++) begin
            load_reg(T0, $urandom);
            load_reg(T1, $urandom);  // high bits exercise shamt masking
            imm = 12'($urandom);
            issue(op_instr(i % 19, imm));
            settle_and_check();
        end
    endtask

    task automatic dependent_chains();
        issue(enc_i(F3_ADD, A0, X0, 12'h010));
        repeat (8) issue(enc_i(F3_ADD, A0, A0, 12'd1));  // each hits W forwarding
        settle_and_check();
        issue(enc_i(F3_ADD, T0, X0, 12'd3));
        issue(enc_i(F3_ADD, T1, X0, 12'd5));
        issue(enc_r(F7_BASE, F3_ADD, T0, T0, T1));
        issue(enc_r(F7_ALT, F3_ADD, T1, T0, T1));
        issue(enc_r(F7_BASE, F3_XOR, T0, T1, T0));
        issue(enc_r(F7_BASE, F3_SLL, T1, T0, T1));
        issue(enc_r(F7_BASE, F3_ADD, A0, T0, T1));
        settle_and_check();
    endtask

    task automatic x0_write_discard();
        issue(enc_i(F3_ADD, X0, X0, 12'd5));
        issue(enc_r(F7_BASE, F3_ADD, A0, X0, X0));
        settle_and_check();
        check_a0(32'd0);
    endtask

    task automatic illegal_encodings();
        issue(enc_i(F3_ADD, A0, X0, 12'h5A5));
        settle_and_check();
        expect_illegal({7'h00, 5'(T1), 5'(T0), 3'b000, 5'(A0), 7'b1111111});
        expect_illegal(enc_r(7'b0000001, F3_ADD, A0, T0, T1));  // mul is not in the subset
    endtask

    task automatic valid_gaps();
        issue(enc_i(F3_ADD, T0, X0, 12'd7));
        gap(enc_i(F3_ADD, A0, X0, 12'd99));
        issue(enc_i(F3_ADD, A0, T0, 12'd5));
        gap(enc_i(F3_ADD, A0, X0, 12'd99));
        gap(enc_r(F7_BASE, F3_ADD, T0, A0, A0));
        issue(enc_r(F7_BASE, F3_ADD, A0, A0, T0));
        settle_and_check();
    endtask

    // hard stop if a test never returns
    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout, tests did not finish within %0d cycles", MAX_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        int assert_fails;
        errors       = 0;
        shadow[0]    = '0;
        rst_n       <= 1'b0;
        instr       <= '0;
        instr_valid <= 1'b0;
        void'($urandom(52));  // fixed seed
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (illegal_instr === 1'b0)
        else begin
            errors++;
            $display("FAIL %0t illegal_instr expected 0 got %b", $time, illegal_instr);
        end
        lui_addi_constant();
        all_ops_random();
        dependent_chains();
        x0_write_discard();
        illegal_encodings();
        valid_gaps();
        assert_fails = exec_pipe_inst.exec_pipe_asserts_inst.fail_count;
        $display("checks failed: %0d, assertions failed: %0d", errors, assert_fails);
        if (errors == 0 && assert_fails == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

/* files.f */
source/rv_pkg.sv
source/regfile.sv
source/decoder.sv
source/alu.sv
source/forward_unit.sv
source/exec_pipe.sv
bench/exec_pipe_asserts.sv
bench/exec_pipe_tb.sv
